//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pdp8_ac
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' project.f) include/ac_model.svh

.PHONY: all run clean

all: run

$(SIM): project.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f project.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- hw/ac_bus_slave.sv
// host must hold cyc, stb and dat_w until ack and drop stb the cycle after
module ac_bus_slave
    import ac_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  logic      adr,
    input  ac_cmd_t   dat_w,
    input  ac_regs_t  regs,
    input  logic      eae_done,
    output logic      ack,
    output ac_regs_t  dat_r,
    output op_class_t op,
    output ac_cmd_t   cmd,
    output logic      exec,
    output logic      start
);
    typedef enum logic [1:0] {S_IDLE, S_EXEC, S_EAE, S_ACK} state_t;

    state_t    state;
    op_class_t dec_op;
    logic      wr_q;
    logic      is_eae;

    // reads decode to op_none so nothing downstream moves
    always_comb
    begin
        dec_op = op_none;
        if (we)
        begin
            if (dat_w.instruction == INSN_MUL)
                dec_op = op_mul;
            else if (dat_w.instruction == INSN_SHL)
                dec_op = op_shl;
            else if (dat_w.instruction == INSN_LSR)
                dec_op = op_lsr;
            else if (dat_w.instruction == INSN_ASR)
                dec_op = op_asr;
            else if (dat_w.instruction[0:2] == OPC_AND)
                dec_op = op_and;
            else if (dat_w.instruction[0:2] == OPC_TAD)
                dec_op = op_tad;
            else if (dat_w.instruction[0:2] == OPC_DCA)
                dec_op = op_dca;
            else if (dat_w.instruction[0:3] == 4'b1110)
                dec_op = op_group1;
            else if (dat_w.instruction[0:3] == 4'b1111 && dat_w.instruction[11])
                dec_op = op_group3;
        end
    end

    assign is_eae = (op == op_mul) || (op == op_shl) || (op == op_lsr) || (op == op_asr);
    assign exec   = (state == S_EXEC) && wr_q && !is_eae;
    assign start  = (state == S_EXEC) && wr_q && is_eae;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            op    <= op_none;
            wr_q  <= 1'b0;
            ack   <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            case (state)
                S_IDLE:
                    if (cyc && stb)
                    begin
                        op    <= dec_op;
                        wr_q  <= we;
                        state <= S_EXEC;
                    end
                S_EXEC:
                    if (is_eae && !eae_done)
                        state <= S_EAE;  // long shifts and MUL iterate
                    else
                    begin
                        ack   <= 1'b1;
                        state <= S_ACK;
                    end
                S_EAE:
                    if (eae_done)
                    begin
                        ack   <= 1'b1;
                        state <= S_ACK;
                    end
                S_ACK:
                    if (!(cyc && stb))
                        state <= S_IDLE;  // wait out the held strobe
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && cyc && stb)
            cmd <= dat_w;
        if (state == S_EXEC && !wr_q)
        begin
            case (adr)
                WB_ADDR_REGS, WB_ADDR_MQ: dat_r <= regs;  // same struct in both windows
            endcase
        end
    end

    a_ack_with_stb: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb));
    a_ack_single:   assert property (@(posedge clk) disable iff (reset) ack |=> !ack);
    a_start_exec:   assert property (@(posedge clk) disable iff (reset) !(start && exec));

endmodule

//--- hw/ac_pkg.sv
// words are big-endian (bit 0 is the MSB) and only EAE mode A opcodes are defined
package ac_pkg;

    localparam int WORD_BITS   = 12;
    localparam int SHIFT_LIMIT = 24;  // shift counts from here on clear everything

    typedef logic [0:WORD_BITS-1] word_t;

    // one host command, written as a single bus word
    typedef struct packed {
        word_t instruction;
        word_t operand;      // memory word, shift count or multiplier
    } ac_cmd_t;

    // architectural state, also the read data layout
    typedef struct packed {
        logic  link;
        word_t ac;
        word_t mq;
    } ac_regs_t;

    typedef enum logic [3:0] {
        op_none,     // no register change
        op_and,
        op_tad,
        op_dca,
        op_group1,   // operate microcode
        op_group3,   // MQ microcode
        op_mul,
        op_shl,
        op_lsr,
        op_asr
    } op_class_t;

    // memory reference op field, instruction bits 0 to 2
    localparam logic [0:2] OPC_AND = 3'o0;
    localparam logic [0:2] OPC_TAD = 3'o1;
    localparam logic [0:2] OPC_DCA = 3'o3;

    // complete EAE words, matched exactly
    localparam word_t INSN_MUL = 12'o7405;
    localparam word_t INSN_SHL = 12'o7413;
    localparam word_t INSN_ASR = 12'o7415;
    localparam word_t INSN_LSR = 12'o7417;

    // read windows
    localparam logic WB_ADDR_REGS = 1'b0;
    localparam logic WB_ADDR_MQ   = 1'b1;

endpackage

//--- hw/accumulator.sv
// link, AC and MQ clear on reset; exec and eae_write must not overlap
module accumulator
    import ac_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     exec,
    input  logic     eae_write,
    input  ac_regs_t next_regs,
    input  ac_regs_t eae_regs,
    output ac_regs_t regs
);
    ac_regs_t regs_d;

    // pick the source for this edge
    always_comb
    begin
        regs_d = regs;  // hold by default
        if (eae_write)
            regs_d = eae_regs;  // setup and every EAE step
        else if (exec)
            regs_d = next_regs;  // single cycle instructions
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            regs <= '0;
        else
            regs <= regs_d;
    end

    a_one_source: assert property (@(posedge clk) disable iff (reset) !(exec && eae_write));

endmodule

//--- hw/eae_unit.sv
// mode A only; op and operand must stay stable from start until done
module eae_unit
    import ac_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  op_class_t op,
    input  word_t     operand,
    input  ac_regs_t  regs,
    output ac_regs_t  eae_regs,
    output logic      eae_write,
    output logic      done
);
    logic [4:0]  sc;
    logic        busy;
    logic [4:0]  count;
    logic        big;
    logic        shift_op;
    logic [0:12] mul_sum;
    logic [0:12] mul_top;
    ac_regs_t    setup_regs;
    ac_regs_t    step_regs;

    assign count    = operand[7:11];
    assign big      = (count >= 5'(SHIFT_LIMIT));
    assign shift_op = (op == op_shl) || (op == op_lsr) || (op == op_asr);

    // multiplicand added only when the low MQ bit is set
    assign mul_sum = {1'b0, regs.ac} + {1'b0, operand};
    assign mul_top = regs.mq[11] ? mul_sum : {1'b0, regs.ac};

    // setup cycle values
    always_comb
    begin
        setup_regs = regs;
        case (op)
            op_mul:
                setup_regs.link = 1'b0;
            op_shl, op_lsr:
                if (big)
                    setup_regs = '0;
                else
                    setup_regs.link = 1'b0;
            op_asr:
                if (big)
                    setup_regs = {25{regs.ac[0]}};  // sign everywhere
                else
                    setup_regs.link = regs.ac[0];  // link feeds the sign in
            default: ;
        endcase
    end

    // one iteration
    always_comb
    begin
        step_regs = regs;
        case (op)
            op_mul:
                {step_regs.ac, step_regs.mq} = {mul_top, regs.mq[0:10]};
            op_shl:
                {step_regs.link, step_regs.ac, step_regs.mq} = {regs.ac, regs.mq, 1'b0};
            op_lsr, op_asr:
                {step_regs.ac, step_regs.mq} = {regs.link, regs.ac, regs.mq[0:10]};
            default: ;
        endcase
    end

    assign eae_regs  = busy ? step_regs : setup_regs;
    assign eae_write = start || busy;
    assign done      = (start && shift_op && big) || (busy && sc == 5'd1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sc   <= 5'd0;
            busy <= 1'b0;
        end
        else if (start)
        begin
            if (op == op_mul)
            begin
                sc   <= 5'(WORD_BITS);
                busy <= 1'b1;
            end
            else if (shift_op && !big)
            begin
                sc   <= count + 5'd1;  // mode A shifts one extra place
                busy <= 1'b1;
            end
        end
        else if (busy)
        begin
            sc <= sc - 5'd1;
            if (sc == 5'd1)
                busy <= 1'b0;
        end
    end

    a_sc_range: assert property (@(posedge clk) disable iff (reset) busy |-> (sc <= 5'd25));

endmodule

//--- hw/operate_unit.sv
// combinational only; op_none and any unlisted microcode bits leave the registers as they are
module operate_unit
    import ac_pkg::*;
(
    input  op_class_t op,
    input  ac_cmd_t   cmd,
    input  ac_regs_t  regs,
    output ac_regs_t  next_regs
);
    word_t       insn;
    logic [0:12] lac_clr;
    logic [0:12] lac_cmp;
    logic [0:12] lac_inc;
    logic [0:12] lac_rot;
    logic [0:12] tad_sum;
    word_t       g3_ac;

    assign insn = cmd.instruction;

    // group 1 runs clear, complement, increment, then rotate
    assign lac_clr = {regs.link & ~insn[5], regs.ac & {12{~insn[4]}}};  // CLL, CLA
    assign lac_cmp = lac_clr ^ {insn[7], {12{insn[6]}}};                 // CML, CMA
    assign lac_inc = lac_cmp + {12'b0, insn[11]};                        // IAC carries into link

    always_comb
    begin
        case (insn[8:10])
            3'b001:  lac_rot = {lac_inc[0], lac_inc[7:12], lac_inc[1:6]};  // BSW keeps link
            3'b010:  lac_rot = {lac_inc[1:12], lac_inc[0]};                // RAL
            3'b011:  lac_rot = {lac_inc[2:12], lac_inc[0:1]};              // RTL
            3'b100:  lac_rot = {lac_inc[12], lac_inc[0:11]};               // RAR
            3'b101:  lac_rot = {lac_inc[11:12], lac_inc[0:10]};            // RTR
            default: lac_rot = lac_inc;
        endcase
    end

    // 13-bit add, so the carry out flips the link
    assign tad_sum = {regs.link, regs.ac} + {1'b0, cmd.operand};

    // group 3 CLA happens before the MQ moves
    assign g3_ac = insn[4] ? '0 : regs.ac;

    always_comb
    begin
        next_regs = regs;
        case (op)
            op_and:
                next_regs.ac = regs.ac & cmd.operand;
            op_tad:
                {next_regs.link, next_regs.ac} = tad_sum;
            op_dca:
                next_regs.ac = '0;  // no store path here
            op_group1:
                {next_regs.link, next_regs.ac} = lac_rot;
            op_group3:
            begin
                case ({insn[5], insn[7]})
                    2'b01:  // MQL
                    begin
                        next_regs.mq = g3_ac;
                        next_regs.ac = '0;
                    end
                    2'b10:  // MQA
                        next_regs.ac = g3_ac | regs.mq;
                    2'b11:  // SWP
                    begin
                        next_regs.mq = g3_ac;
                        next_regs.ac = regs.mq;
                    end
                    default:
                        next_regs.ac = g3_ac;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- hw/pdp8_ac_top.sv
// one command in flight; EAE latency varies, so the host waits on ack
module pdp8_ac_top
    import ac_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     cyc,
    input  logic     stb,
    input  logic     we,
    input  logic     adr,
    input  ac_cmd_t  dat_w,
    output logic     ack,
    output ac_regs_t dat_r
);
    op_class_t op;
    ac_cmd_t   cmd;
    logic      exec;
    logic      start;
    logic      eae_write;
    logic      eae_done;
    ac_regs_t  regs;
    ac_regs_t  next_regs;
    ac_regs_t  eae_regs;

    ac_bus_slave u_slave (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .regs(regs), .eae_done(eae_done), .ack(ack), .dat_r(dat_r),
        .op(op), .cmd(cmd), .exec(exec), .start(start)
    );

    operate_unit u_operate (.op(op), .cmd(cmd), .regs(regs), .next_regs(next_regs));

    eae_unit u_eae (
        .clk(clk), .reset(reset), .start(start), .op(op), .operand(cmd.operand),
        .regs(regs), .eae_regs(eae_regs), .eae_write(eae_write), .done(eae_done)
    );

    accumulator u_acc (
        .clk(clk), .reset(reset), .exec(exec), .eae_write(eae_write),
        .next_regs(next_regs), .eae_regs(eae_regs), .regs(regs)
    );

endmodule

//--- project.f
+incdir+include
hw/ac_pkg.sv
hw/ac_bus_slave.sv
hw/operate_unit.sv
hw/eae_unit.sv
hw/accumulator.sv
hw/pdp8_ac_top.sv
test/tb_pdp8_ac.sv

//--- include/ac_model.svh
// expected state after one command; mode A EAE only, unknown words leave the registers alone
`ifndef AC_MODEL_SVH
`define AC_MODEL_SVH

function automatic ac_pkg::ac_regs_t ac_model(input ac_pkg::ac_regs_t cur,
                                              input ac_pkg::ac_cmd_t cmd);
    ac_pkg::ac_regs_t                r;
    ac_pkg::word_t                   i;
    ac_pkg::word_t                   ac0;
    logic [4:0]                      cnt;
    logic [0:12]                     sum;
    logic [2*ac_pkg::WORD_BITS-1:0]  prod;
    logic signed [23:0]              spair;
    int                              steps;
    int                              n;
    r   = cur;
    i   = cmd.instruction;
    cnt = cmd.operand[7:11];
    if (i == ac_pkg::INSN_MUL)
    begin
        prod = cur.mq * cmd.operand + cur.ac;
        {r.link, r.ac, r.mq} = {1'b0, prod};
    end
    else if (i == ac_pkg::INSN_SHL)
        r = (cnt >= ac_pkg::SHIFT_LIMIT) ? '0 : {1'b0, cur.ac, cur.mq} << (cnt + 5'd1);
    else if (i == ac_pkg::INSN_LSR)
        r = (cnt >= ac_pkg::SHIFT_LIMIT) ? '0 : {1'b0, {cur.ac, cur.mq} >> (cnt + 5'd1)};
    else if (i == ac_pkg::INSN_ASR)
    begin
        spair = {cur.ac, cur.mq};
        spair = spair >>> ((cnt >= ac_pkg::SHIFT_LIMIT) ? 5'd24 : cnt + 5'd1);
        {r.link, r.ac, r.mq} = {cur.ac[0], spair};
    end
    else if (i[0:2] == ac_pkg::OPC_AND)
        r.ac = cur.ac & cmd.operand;
    else if (i[0:2] == ac_pkg::OPC_TAD)
    begin
        sum    = {1'b0, cur.ac} + {1'b0, cmd.operand};  // carry out lands in bit 0
        r.ac   = sum[1:12];
        r.link = cur.link ^ sum[0];
    end
    else if (i[0:2] == ac_pkg::OPC_DCA)
        r.ac = '0;
    else if (i[0:3] == 4'b1110)
    begin
        if (i[4])
            r.ac = '0;  // CLA
        if (i[5])
            r.link = 1'b0;  // CLL
        if (i[6])
            r.ac = ~r.ac;  // CMA
        if (i[7])
            r.link = ~r.link;  // CML
        if (i[11])
            {r.link, r.ac} = {r.link, r.ac} + 13'd1;  // IAC
        steps = i[10] ? 2 : 1;
        if (i[8] && !i[9])
        begin
            for (n = 0; n < steps; n++)
                {r.link, r.ac} = {r.ac[11], r.link, r.ac[0:10]};  // RAR, RTR
        end
        else if (i[9] && !i[8])
        begin
            for (n = 0; n < steps; n++)
                {r.link, r.ac} = {r.ac, r.link};  // RAL, RTL
        end
        else if (i[10] && !i[8] && !i[9])
            r.ac = {r.ac[6:11], r.ac[0:5]};  // BSW
    end
    else if (i[0:3] == 4'b1111 && i[11])
    begin
        ac0  = i[4] ? '0 : cur.ac;  // CLA comes first
        r.ac = (i[5] ? cur.mq : 12'o0000) | (i[7] ? 12'o0000 : ac0);
        r.mq = i[7] ? ac0 : cur.mq;
    end
    return r;
endfunction

`endif

//--- test/tb_pdp8_ac.sv
// one command at a time over Wishbone; registers are loaded through TAD, MQL and CML
module tb_pdp8_ac
    import ac_pkg::*;
();
    logic     clk;
    logic     reset;
    logic     cyc;
    logic     stb;
    logic     we;
    logic     adr;
    ac_cmd_t  dat_w;
    logic     ack;
    ac_regs_t dat_r;

    ac_regs_t expected;  // model state after the last write
    logic     cmp_req;   // set by the stimulus, cleared by the compare process
    logic     rd_sel;    // alternates the two read windows
    integer   seed;
    int       n_checks;
    int       n_errors;
    int       n_tests;

`include "ac_model.svh"

    pdp8_ac_top DUT (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .ack(ack), .dat_r(dat_r)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    task automatic abort(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $finish;
    endtask

    function automatic word_t rand_word();
        logic [31:0] v;
        v = $random(seed);
        return v[11:0];
    endfunction

    task automatic check(input string name, input logic [11:0] got, input logic [11:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_ack(input string what);
        int n;
        n = 0;
        while (ack !== 1'b1 && n < 200)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ack !== 1'b1)
            abort({"no acknowledge for a bus ", what, " within 200 cycles"});
    endtask

    task automatic bus_write(input ac_cmd_t c);
        @(posedge clk);
        #1;
        {cyc, stb, we, adr, dat_w} = {3'b111, WB_ADDR_REGS, c};
        wait_ack("write");
        @(posedge clk);  // strobe held through the ack edge
        #1;
        {cyc, stb, we} = 3'b000;
    endtask

    task automatic bus_read(input logic a, output ac_regs_t r);
        @(posedge clk);
        #1;
        {cyc, stb, we, adr} = {3'b110, a};
        wait_ack("read");
        r = dat_r;
        @(posedge clk);
        #1;
        {cyc, stb} = 2'b00;
    endtask

    // reads back and compares whenever the stimulus asks
    always
    begin
        ac_regs_t got;
        @(posedge clk);
        if (cmp_req)
        begin
            bus_read(rd_sel, got);
            check("link", {11'b0, got.link}, {11'b0, expected.link});
            check("ac", got.ac, expected.ac);
            check("mq", got.mq, expected.mq);
            rd_sel  = ~rd_sel;
            cmp_req = 1'b0;
        end
    end

    task automatic compare_now();
        int n;
        cmp_req = 1'b1;
        n = 0;
        while (cmp_req && n < 500)
        begin
            @(negedge clk);
            n++;
        end
        if (cmp_req)
            abort("compare process did not finish its read back");
    endtask

    task automatic do_command(input word_t insn, input word_t operand);
        ac_cmd_t c;
        c.instruction = insn;
        c.operand     = operand;
        bus_write(c);
        expected = ac_model(expected, c);
        compare_now();
    endtask

    // random link, AC and MQ built from CLA CLL, TAD, MQL, TAD, CML
    task automatic load_random();
        word_t l;
        l = rand_word();
        do_command(12'o7300, 12'o0000);
        do_command(12'o1000, rand_word());
        do_command(12'o7421, 12'o0000);
        do_command(12'o1000, rand_word());
        if (l[0])
            do_command(12'o7020, 12'o0000);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before)
            $display("test %0d %s: ok", n_tests, name);
        else
            $display("test %0d %s: %0d errors", n_tests, name, n_errors - errs_before);
    endtask

    initial
    begin
        int    e;
        int    k;
        word_t w;
        word_t g3_words [0:5];
        word_t shift_words [0:2];
        g3_words    = '{12'o7421, 12'o7501, 12'o7521, 12'o7621, 12'o7701, 12'o7721};
        shift_words = '{INSN_SHL, INSN_LSR, INSN_ASR};
        seed     = 32'h8aff;
        reset    = 1'b1;
        {cyc, stb, we, adr} = 4'b0000;
        dat_w    = '0;
        expected = '0;
        cmp_req  = 1'b0;
        rd_sel   = WB_ADDR_REGS;
        n_checks = 0;
        n_errors = 0;
        n_tests  = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        e = n_errors;
        compare_now();
        finish_test("reset state", e);

        e = n_errors;
        repeat (40)
        begin
            load_random();
            w = rand_word();
            do_command({4'b1110, w[4:11]}, rand_word());
        end
        finish_test("group 1 microcode", e);

        e = n_errors;
        for (k = 0; k < 30; k++)
        begin
            load_random();
            w = rand_word();
            w[0:2] = (k % 3 == 0) ? OPC_AND : (k % 3 == 1) ? OPC_TAD : OPC_DCA;
            do_command(w, rand_word());
        end
        finish_test("AND TAD DCA", e);

        e = n_errors;
        for (k = 0; k < 18; k++)
        begin
            load_random();
            do_command(g3_words[k % 6], rand_word());
        end
        finish_test("group 3 MQ microcode", e);

        e = n_errors;
        repeat (10)
        begin
            load_random();
            do_command(INSN_MUL, rand_word());
        end
        finish_test("MUL", e);

        e = n_errors;
        for (k = 0; k < 42; k++)
        begin
            load_random();
            w = rand_word();
            if (k % 14 < 8)
                w[7:11] = 5'(24 + k % 14);  // counts 24 to 31
            do_command(shift_words[k / 14], w);
        end
        finish_test("SHL LSR ASR", e);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
